// File: common/mul16_macros.svh
// ----------------------------------------
// mul16 widths
// Operand, half-word and lookahead group sizes
// ----------------------------------------
`ifndef MUL16_MACROS_SVH
`define MUL16_MACROS_SVH

// Full operand width
`define MUL16_WIDTH 16

// Width of one operand half
`define MUL16_HALF 8

`define MUL16_CLA_GROUP 4

`endif

// File: common/mul16_pkg.sv
// ----------------------------------------
// mul16 types
// Operand, partial-product and product words
// ----------------------------------------
`include "mul16_macros.svh"

package mul16_pkg;

  typedef logic [`MUL16_WIDTH-1:0] operand_t;
  typedef logic [`MUL16_HALF-1:0] half_t;

  // One 8 x 8 product
  typedef logic [2*`MUL16_HALF-1:0] partial_t;

  // Full product, also the adder word
  typedef logic [2*`MUL16_WIDTH-1:0] product_t;

  typedef logic [`MUL16_CLA_GROUP-1:0] cla_group_t;

endpackage

// File: source/array_mult8.sv
// ----------------------------------------
// array_mult8
// Exact 8 x 8 unsigned carry-save array multiplier
// ----------------------------------------
`timescale 1ns/1ns
`include "mul16_macros.svh"

module array_mult8 (
  input  mul16_pkg::half_t    a,
  input  mul16_pkg::half_t    b,
  output mul16_pkg::partial_t p
);

  import mul16_pkg::*;

  localparam int unsigned N = `MUL16_HALF;

  // Both return {carry, sum}
  function automatic logic [1:0] half_add(input logic x, input logic y);
    return {x & y, x ^ y};
  endfunction

  function automatic logic [1:0] full_add(input logic x, input logic y, input logic z);
    return {(x & y) | (z & (x ^ y)), x ^ y ^ z};
  endfunction

  // Element [i][j] sits at weight i+j and its carry one higher
  logic [N-1:0] pp [N];
  logic [N-1:0] s  [N];
  logic [N-2:0] c  [1:N-1];
  logic [N-1:1] rc;
  partial_t     res;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      pp[i] = a & {N{b[i]}};
    end
  end

  // Carry-save rows with carries dropping to the next row
  always_comb begin
    s[0] = pp[0];
    for (int i = 1; i < N; i++) begin
      // Only the partial-product bit reaches the top column
      s[i][N-1] = pp[i][N-1];
      for (int j = 0; j < N-1; j++) begin
        if (i == 1) begin
          {c[i][j], s[i][j]} = half_add(pp[i][j], s[i-1][j+1]);
        end else begin
          {c[i][j], s[i][j]} = full_add(pp[i][j], s[i-1][j+1], c[i-1][j]);
        end
      end
    end
  end

  // Low bits fall out of the array and the upper half comes from a ripple row
  always_comb begin
    for (int i = 0; i < N; i++) begin
      res[i] = s[i][0];
    end
    {rc[1], res[N]} = half_add(s[N-1][1], c[N-1][0]);
    for (int j = 1; j < N-1; j++) begin
      {rc[j+1], res[N+j]} = full_add(s[N-1][j+1], c[N-1][j], rc[j]);
    end
    // Exact product never carries past bit 15
    res[2*N-1] = rc[N-1];
  end

  assign p = res;

endmodule

// File: cla_adder/cla_group4.sv
// ----------------------------------------
// cla_group4
// 4-bit lookahead group, carries and sum
// ----------------------------------------
`timescale 1ns/1ns

module cla_group4 (
  input  mul16_pkg::cla_group_t prop,
  input  mul16_pkg::cla_group_t gen,
  input  logic                  cin,
  output mul16_pkg::cla_group_t sum
);

  import mul16_pkg::*;

  cla_group_t carry;

  // Internal carries expanded from the group carry-in
  assign carry[0] = cin;
  assign carry[1] = gen[0] | (prop[0] & cin);
  assign carry[2] = gen[1]
                  | (prop[1] & gen[0])
                  | (prop[1] & prop[0] & cin);
  assign carry[3] = gen[2]
                  | (prop[2] & gen[1])
                  | (prop[2] & prop[1] & gen[0])
                  | (prop[2] & prop[1] & prop[0] & cin);

  assign sum = prop ^ carry;

endmodule

// File: cla_adder/cla_adder32.sv
// ----------------------------------------
// cla_adder32
// 32-bit block carry-lookahead adder,
// eight 4-bit groups, carry out dropped
// ----------------------------------------
`timescale 1ns/1ns
`include "mul16_macros.svh"

module cla_adder32 (
  input  mul16_pkg::product_t a,
  input  mul16_pkg::product_t b,
  output mul16_pkg::product_t sum
);

  import mul16_pkg::*;

  localparam int unsigned G  = `MUL16_CLA_GROUP;
  localparam int unsigned NG = $bits(product_t) / G;

  product_t p_bit;
  product_t g_bit;

  // Top group feeds only the discarded carry out
  logic [NG-2:0] grp_p;
  logic [NG-2:0] grp_g;
  logic [NG-1:0] grp_c;

  assign p_bit = a ^ b;
  assign g_bit = a & b;

  always_comb begin
    logic term;
    for (int k = 0; k < NG-1; k++) begin
      grp_p[k] = &p_bit[k*G +: G];
      grp_g[k] = 1'b0;
      for (int m = 0; m < G; m++) begin
        term = g_bit[k*G+m];
        for (int n = m+1; n < G; n++) begin
          term = term & p_bit[k*G+n];
        end
        grp_g[k] = grp_g[k] | term;
      end
    end

    // Flat block lookahead, nothing carries into group 0
    grp_c[0] = 1'b0;
    for (int k = 1; k < NG; k++) begin
      grp_c[k] = 1'b0;
      for (int m = 0; m < k; m++) begin
        term = grp_g[m];
        for (int n = m+1; n < k; n++) begin
          term = term & grp_p[n];
        end
        grp_c[k] = grp_c[k] | term;
      end
    end
  end

  for (genvar k = 0; k < NG; k++) begin : g_group
    cla_group4 group_i (
      .prop (p_bit[k*G +: G]),
      .gen  (g_bit[k*G +: G]),
      .cin  (grp_c[k]),
      .sum  (sum[k*G +: G])
    );
  end

endmodule

// File: mul16/partial_product_stage.sv
// ----------------------------------------
// partial_product_stage
// Stage 1: four half-word products, registered
// ----------------------------------------
`timescale 1ns/1ns
`include "mul16_macros.svh"

module partial_product_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                in_valid,
  input  mul16_pkg::operand_t a,
  input  mul16_pkg::operand_t b,
  output logic                pp_valid,
  output mul16_pkg::partial_t pp_ll,
  output mul16_pkg::partial_t pp_lh,
  output mul16_pkg::partial_t pp_hl,
  output mul16_pkg::partial_t pp_hh
);

  import mul16_pkg::*;

  half_t    a_lo, a_hi;
  half_t    b_lo, b_hi;
  partial_t ll, lh, hl, hh;

  assign a_lo = a[`MUL16_HALF-1:0];
  assign a_hi = a[`MUL16_WIDTH-1:`MUL16_HALF];
  assign b_lo = b[`MUL16_HALF-1:0];
  assign b_hi = b[`MUL16_WIDTH-1:`MUL16_HALF];

  // First letter is the half of a, second the half of b
  array_mult8 mult_ll_i (.a(a_lo), .b(b_lo), .p(ll));
  array_mult8 mult_lh_i (.a(a_lo), .b(b_hi), .p(lh));
  array_mult8 mult_hl_i (.a(a_hi), .b(b_lo), .p(hl));
  array_mult8 mult_hh_i (.a(a_hi), .b(b_hi), .p(hh));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pp_valid <= 1'b0;
    end else begin
      pp_valid <= in_valid;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pp_ll <= '0;
      pp_lh <= '0;
      pp_hl <= '0;
      pp_hh <= '0;
    end else if (in_valid) begin
      pp_ll <= ll;
      pp_lh <= lh;
      pp_hl <= hl;
      pp_hh <= hh;
    end
  end

endmodule

// File: mul16/product_sum_stage.sv
// ----------------------------------------
// product_sum_stage
// Stage 2: align and add partial products
// ----------------------------------------
`timescale 1ns/1ns
`include "mul16_macros.svh"

module product_sum_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                pp_valid,
  input  mul16_pkg::partial_t pp_ll,
  input  mul16_pkg::partial_t pp_lh,
  input  mul16_pkg::partial_t pp_hl,
  input  mul16_pkg::partial_t pp_hh,
  output logic                out_valid,
  output mul16_pkg::product_t product
);

  import mul16_pkg::*;

  product_t base;
  product_t lh_shifted;
  product_t hl_shifted;
  product_t first_sum;
  product_t final_sum;

  // hh and ll do not overlap, so they just concatenate
  assign base       = {pp_hh, pp_ll};
  assign lh_shifted = {{`MUL16_HALF{1'b0}}, pp_lh, {`MUL16_HALF{1'b0}}};
  assign hl_shifted = {{`MUL16_HALF{1'b0}}, pp_hl, {`MUL16_HALF{1'b0}}};

  cla_adder32 add_lh_i (.a(base), .b(lh_shifted), .sum(first_sum));
  cla_adder32 add_hl_i (.a(first_sum), .b(hl_shifted), .sum(final_sum));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      product   <= '0;
    end else begin
      out_valid <= pp_valid;
      if (pp_valid) begin
        product <= final_sum;
      end
    end
  end

endmodule

// File: mul16/mul16_top.sv
// ----------------------------------------
// mul16_top
// Two-stage pipelined 16 x 16 multiplier
// ----------------------------------------
`timescale 1ns/1ns

module mul16_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                in_valid,
  input  mul16_pkg::operand_t a,
  input  mul16_pkg::operand_t b,
  output logic                out_valid,
  output mul16_pkg::product_t product
);

  import mul16_pkg::*;

  // Stage 1 to stage 2
  logic     pp_valid;
  partial_t pp_ll;
  partial_t pp_lh;
  partial_t pp_hl;
  partial_t pp_hh;

  partial_product_stage pp_stage_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .pp_valid (pp_valid),
    .pp_ll    (pp_ll),
    .pp_lh    (pp_lh),
    .pp_hl    (pp_hl),
    .pp_hh    (pp_hh)
  );

  product_sum_stage sum_stage_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .pp_valid  (pp_valid),
    .pp_ll     (pp_ll),
    .pp_lh     (pp_lh),
    .pp_hl     (pp_hl),
    .pp_hh     (pp_hh),
    .out_valid (out_valid),
    .product   (product)
  );

endmodule

// File: verification/mul16_tb.sv
// ----------------------------------------
// mul16_tb
// Testbench for the pipelined 16 x 16
// multiplier with scoreboard and assertions
// ----------------------------------------
`timescale 1ns/1ns

module mul16_tb;

  import mul16_pkg::*;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned RESET_CYCLES = 4;
  localparam int unsigned CORNER_N = 10;
  localparam int unsigned RANDOM_N = 1000;
  localparam int unsigned BUBBLE_N = 400;
  localparam int unsigned CARRY_N = 8;
  localparam int unsigned DRAIN_CYCLES = 8;
  localparam int unsigned MARGIN_CYCLES = 100;
  localparam int unsigned RUN_CYCLES = RESET_CYCLES + 4 + CORNER_N + RANDOM_N + BUBBLE_N
                                     + CARRY_N + 5 * DRAIN_CYCLES + MARGIN_CYCLES;

  logic     clk;
  logic     arst_n;
  logic     in_valid;
  operand_t a;
  operand_t b;
  logic     out_valid;
  product_t product;

  // Reference model state
  logic     exp_v1 = 1'b0;
  logic     exp_valid = 1'b0;
  product_t exp_front = '0;
  product_t exp_q[$];

  string       cur_test = "init";
  int unsigned err_count = 0;
  int unsigned err_at_start = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;

  mul16_top dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic product_t expected_product(input operand_t x, input operand_t y);
    product_t wide_x;
    product_t wide_y;
    wide_x = x;
    wide_y = y;
    return wide_x * wide_y;
  endfunction

  // Two-cycle valid model and in-order queue of products
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_v1    <= 1'b0;
      exp_valid <= 1'b0;
      exp_q.delete();
      exp_front = '0;
    end else begin
      if (exp_valid && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (in_valid) begin
        exp_q.push_back(expected_product(a, b));
      end
      exp_front = (exp_q.size() != 0) ? exp_q[0] : '0;
      exp_v1    <= in_valid;
      exp_valid <= exp_v1;
    end
  end

  task automatic flag_mismatch(input string what, input product_t expv, input product_t actv);
    err_count++;
    $display("Error: %s %s expected 0x%08h actual 0x%08h", cur_test, what, expv, actv);
  endtask

  task automatic flag_failure(input string msg);
    err_count++;
    $display("Failure in %s: %s", cur_test, msg);
  endtask

  // Sampled at the falling edge where DUT outputs and inputs are settled
  valid_matches: assert property (@(negedge clk) out_valid == exp_valid)
    else flag_mismatch("out_valid", product_t'(exp_valid), product_t'(out_valid));

  product_matches: assert property (@(negedge clk) out_valid |-> (product == exp_front))
    else flag_mismatch("product", exp_front, product);

  reset_quiet: assert property (@(negedge clk) !arst_n |-> (!out_valid && product == '0))
    else flag_failure("out_valid or product not cleared while reset is active");

  task automatic drive_cycle(input logic v, input operand_t x, input operand_t y);
    in_valid = v;
    a        = x;
    b        = y;
    @(posedge clk);
    #2;
  endtask

  // Idle cycles carry junk operands that must not load
  task automatic drive_idle(input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      drive_cycle(1'b0, operand_t'($urandom), operand_t'($urandom));
    end
  endtask

  task automatic drain_pipeline();
    drive_idle(1);
    while (exp_q.size() != 0) begin
      drive_idle(1);
    end
    drive_idle(2);
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = err_count;
  endtask

  task automatic finish_test();
    int unsigned n_err;
    n_err = err_count - err_at_start;
    tests_run++;
    if (n_err == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, n_err);
    end
  endtask

  task automatic run_reset();
    start_test("reset");
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    arst_n   = 1'b1;
    #1;
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;
    drive_idle(3);
    assert (out_valid == 1'b0)
      else flag_mismatch("out_valid after reset", '0, product_t'(out_valid));
    assert (product == '0)
      else flag_mismatch("product after reset", '0, product);
    finish_test();
  endtask

  task automatic run_corners();
    operand_t xs[CORNER_N];
    operand_t ys[CORNER_N];
    xs = '{16'h0000, 16'hABCD, 16'h0001, 16'h7777, 16'hFFFF,
           16'h0100, 16'h00FF, 16'hFF00, 16'h8000, 16'hFFFF};
    ys = '{16'h1234, 16'h0000, 16'hBEEF, 16'h0001, 16'hFFFF,
           16'h00FF, 16'h0100, 16'h00FF, 16'h8000, 16'h0001};
    start_test("corners");
    for (int i = 0; i < CORNER_N; i++) begin
      drive_cycle(1'b1, xs[i], ys[i]);
    end
    drain_pipeline();
    finish_test();
  endtask

  task automatic run_random();
    start_test("random");
    for (int unsigned i = 0; i < RANDOM_N; i++) begin
      drive_cycle(1'b1, operand_t'($urandom), operand_t'($urandom));
    end
    drain_pipeline();
    finish_test();
  endtask

  task automatic run_bubbles();
    logic v;
    start_test("bubbles");
    for (int unsigned i = 0; i < BUBBLE_N; i++) begin
      v = ($urandom_range(0, 2) != 0);
      drive_cycle(v, operand_t'($urandom), operand_t'($urandom));
    end
    drain_pipeline();
    finish_test();
  endtask

  task automatic run_carries();
    operand_t xs[CARRY_N];
    operand_t ys[CARRY_N];
    // All-ones halves ripple across the 4-bit groups
    xs = '{16'h00FF, 16'hFF01, 16'hFFFF, 16'h0FFF,
           16'hFF00, 16'h00FF, 16'hFFFF, 16'hF0F0};
    ys = '{16'hFF01, 16'h00FF, 16'hFF01, 16'hFFF1,
           16'hFFFF, 16'hFFFF, 16'h0101, 16'h0F0F};
    start_test("carries");
    for (int i = 0; i < CARRY_N; i++) begin
      drive_cycle(1'b1, xs[i], ys[i]);
    end
    drain_pipeline();
    finish_test();
  endtask

  initial begin
    int unsigned seed_val;
    seed_val = $urandom(82);
    run_reset();
    run_corners();
    run_random();
    run_bubbles();
    run_carries();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", RUN_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: mul16.f
+incdir+common
common/mul16_pkg.sv
source/array_mult8.sv
cla_adder/cla_group4.sv
cla_adder/cla_adder32.sv
mul16/partial_product_stage.sv
mul16/product_sum_stage.sv
mul16/mul16_top.sv
verification/mul16_tb.sv

// File: Bender.yml
package:
  name: mul16

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mul16_pkg.sv
      - source/array_mult8.sv
      - cla_adder/cla_group4.sv
      - cla_adder/cla_adder32.sv
      - mul16/partial_product_stage.sv
      - mul16/product_sum_stage.sv
      - mul16/mul16_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/mul16_tb.sv
